//--- design/dac_tx_pkg.sv
// Shared widths, sample and frame types, register map and FSM encodings for the DAC transmit path
package dac_tx_pkg;

  // ******************************
  // Widths and frame geometry
  // ******************************

  // One DAC sample is a 16-bit two's-complement word
  localparam int SAMPLE_W = 16;

  // The JESD link moves data as octets
  localparam int OCTET_W = 8;

  // Sixteen samples go out on every tx_clk cycle
  localparam int NUM_SAMPLES = 16;

  // Four JESD lanes, each carrying eight octets per frame
  localparam int NUM_LANES = 4;
  localparam int OCTETS_PER_LANE = 8;

  // Full frame width, which is 256 bits
  localparam int FRAME_W = NUM_SAMPLES * SAMPLE_W;

  // Host register port widths
  localparam int CFG_ADDR_W = 2;
  localparam int CFG_DATA_W = 16;

  // ******************************
  // Types
  // ******************************

  typedef logic [SAMPLE_W-1:0] sample_t;
  typedef logic [OCTET_W-1:0] octet_t;

  // Sample i occupies bits 16i+15 down to 16i, low octet first
  typedef logic [FRAME_W-1:0] frame_t;

  typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
  typedef logic [CFG_DATA_W-1:0] cfg_data_t;

  // ******************************
  // Register map
  // ******************************

  // Control register holds enable in bit 0 and pattern mode in bit 1
  localparam cfg_addr_t ADDR_CTRL = 2'd0;
  localparam cfg_addr_t ADDR_CONST = 2'd1;
  localparam int CTRL_ENABLE_BIT = 0;
  localparam int CTRL_MODE_BIT = 1;

  // Pattern source mode, encoded as the control register mode bit
  typedef enum logic {
    MODE_RAMP = 1'b0,
    MODE_CONST = 1'b1
  } pattern_mode_e;

  // Host write handshake states
  typedef enum logic {
    CFG_IDLE = 1'b0,
    CFG_ACK = 1'b1
  } cfg_state_e;

endpackage

//--- design/dac_cfg_regs.sv
// Host register block; a four-phase req/ack write port sets the enable, mode and constant sample
`timescale 1ns/1ps

module dac_cfg_regs
  import dac_tx_pkg::*;
(
  input  logic          tx_clk,
  input  logic          reset,
  // Host write port
  input  logic          cfg_req,
  input  cfg_addr_t     cfg_addr,
  input  cfg_data_t     cfg_wdata,
  output logic          cfg_ack,
  // Settings toward the pattern source
  output logic          enable,
  output pattern_mode_e mode,
  output sample_t       const_sample
);

  // ******************************
  // Handshake FSM
  // ******************************

  cfg_state_e state;
  cfg_state_e state_next;

  // A write is taken exactly once, on the edge that leaves CFG_IDLE
  logic write_strobe;

  // Address decode of the current request
  logic sel_ctrl;
  logic sel_const;

  always_comb begin
    state_next = state;
    case (state)
      CFG_IDLE: begin
        // A new request is accepted as soon as it is seen
        if (cfg_req) begin
          state_next = CFG_ACK;
        end
      end
      CFG_ACK: begin
        // Ack is held until the host lets go of req
        if (!cfg_req) begin
          state_next = CFG_IDLE;
        end
      end
      default: begin
        state_next = CFG_IDLE;
      end
    endcase
  end

  always_ff @(posedge tx_clk) begin
    if (reset) begin
      state <= CFG_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Ack comes straight from the state register, so it rises on the write edge
  assign cfg_ack = (state == CFG_ACK);

  assign write_strobe = (state == CFG_IDLE) && cfg_req;

  // Addresses 2 and 3 fall through both selects and are only acknowledged
  assign sel_ctrl = (cfg_addr == ADDR_CTRL);
  assign sel_const = (cfg_addr == ADDR_CONST);

  // ******************************
  // Registers
  // ******************************

  // The control register carries enable and mode
  always_ff @(posedge tx_clk) begin
    if (reset) begin
      enable <= 1'b0;
      mode <= MODE_RAMP;
    end else if (write_strobe && sel_ctrl) begin
      enable <= cfg_wdata[CTRL_ENABLE_BIT];
      mode <= cfg_wdata[CTRL_MODE_BIT] ? MODE_CONST : MODE_RAMP;
    end
  end

  // The constant sample register takes the whole write word
  always_ff @(posedge tx_clk) begin
    if (reset) begin
      const_sample <= '0;
    end else if (write_strobe && sel_const) begin
      const_sample <= sample_t'(cfg_wdata);
    end
  end

  // Upper control bits are reserved and the
  // write data of those bits is dropped here

endmodule

//--- design/dac_pattern_source.sv
// Test pattern generator; produces one ramp or constant frame per tx_clk cycle with a valid flag
`timescale 1ns/1ps

module dac_pattern_source
  import dac_tx_pkg::*;
(
  input  logic          tx_clk,
  input  logic          reset,
  // Settings from the register block
  input  logic          enable,
  input  pattern_mode_e mode,
  input  sample_t       const_sample,
  // Frame toward the lane mapper
  output frame_t        src_frame,
  output logic          src_valid
);

  // ******************************
  // Ramp base counter
  // ******************************

  // First sample of the next ramp frame
  sample_t ramp_base;

  // Frame built from the mode and settings seen on this cycle
  frame_t frame_next;

  // Ramp base after this frame has gone out
  sample_t ramp_base_next;

  // The base moves on by one full frame of samples per ramp cycle
  assign ramp_base_next = ramp_base + sample_t'(NUM_SAMPLES);

  // ******************************
  // Frame build
  // ******************************

  // Sample i is base + i in ramp mode and wraps at 16 bits by width alone
  always_comb begin
    frame_next = '0;
    for (int i = 0; i < NUM_SAMPLES; i++) begin
      if (mode == MODE_CONST) begin
        frame_next[i*SAMPLE_W +: SAMPLE_W] = const_sample;
      end else begin
        frame_next[i*SAMPLE_W +: SAMPLE_W] = ramp_base + sample_t'(i);
      end
    end
  end

  // ******************************
  // Output register
  // ******************************

  // Disable clears the counter so the ramp always restarts at sample 0
  always_ff @(posedge tx_clk) begin
    if (reset || !enable) begin
      ramp_base <= '0;
    end else if (mode == MODE_RAMP) begin
      ramp_base <= ramp_base_next;
    end
  end

  // Constant mode holds the base where it stopped

  // The frame and its flag are registered together, one cycle after the settings
  always_ff @(posedge tx_clk) begin
    if (reset || !enable) begin
      src_frame <= '0;
      src_valid <= 1'b0;
    end else begin
      src_frame <= frame_next;
      src_valid <= 1'b1;
    end
  end

  // A frame is always valid once enabled since the link has no back-pressure

endmodule

//--- design/dac_lane_mapper.sv
// JESD lane mapper; registers each frame once and reorders its octets into the link lane layout
`timescale 1ns/1ps

module dac_lane_mapper
  import dac_tx_pkg::*;
#(
  // 0 keeps the natural lane order, 1 reverses it for the other device variant
  parameter int LANE_ORDER = 0
) (
  input  logic   tx_clk,
  input  logic   reset,
  // Frame from the pattern source
  input  frame_t src_frame,
  input  logic   src_valid,
  // Frame toward the JESD link
  output frame_t tx_data,
  output logic   tx_valid
);

  // Each lane carries two octets per sample group
  localparam int NUM_GROUPS = OCTETS_PER_LANE / 2;

  // ******************************
  // Octet reorder
  // ******************************

  // Combinational image of the frame in lane layout
  frame_t mapped_frame;

  // Output slot t = 8j + 4b + l, where j is the sample group, b the half
  // and l the lane. The high half of each sample goes out first on a lane
  // so b = 0 picks the high octet of the source sample
  for (genvar j = 0; j < NUM_GROUPS; j++) begin : g_group
    for (genvar b = 0; b < 2; b++) begin : g_half
      for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        // Output octet position in the frame
        localparam int SLOT = (2 * NUM_LANES) * j + NUM_LANES * b + l;
        // Lane index after the device specific lane order
        localparam int LANE_SEL = (LANE_ORDER == 1) ? (NUM_LANES - 1 - l) : l;
        // Source sample feeding this lane in this group
        localparam int SAMPLE_SEL = j + NUM_GROUPS * LANE_SEL;
        // Source octet of that sample, high octet on the first half
        localparam int SRC = 2 * SAMPLE_SEL + (1 - b);

        octet_t lane_octet;

        assign lane_octet = src_frame[SRC*OCTET_W +: OCTET_W];
        assign mapped_frame[SLOT*OCTET_W +: OCTET_W] = lane_octet;
      end
    end
  end

  // ******************************
  // Output register
  // ******************************

  // Single pipeline stage, data and valid stay aligned
  always_ff @(posedge tx_clk) begin
    if (reset) begin
      tx_data <= '0;
      tx_valid <= 1'b0;
    end else begin
      tx_data <= mapped_frame;
      tx_valid <= src_valid;
    end
  end

  // A zero source frame while disabled maps to a zero output frame
  // since the reorder only moves octets around

endmodule

//--- design/dac_tx_top.sv
// Top level of the DAC transmit path; register block, pattern source and JESD lane mapper
`timescale 1ns/1ps

module dac_tx_top
  import dac_tx_pkg::*;
#(
  // Lane order of the target device, handed to the mapper
  parameter int LANE_ORDER = 0
) (
  input  logic      tx_clk,
  input  logic      reset,
  // Host write port
  input  logic      cfg_req,
  input  cfg_addr_t cfg_addr,
  input  cfg_data_t cfg_wdata,
  output logic      cfg_ack,
  // Frames toward the JESD link
  output frame_t    tx_data,
  output logic      tx_valid
);

  // ******************************
  // Internal wiring
  // ******************************

  // Settings held between host writes
  logic          enable;
  pattern_mode_e mode;
  sample_t       const_sample;

  // Frame between source and mapper
  frame_t        src_frame;
  logic          src_valid;

  // Register block
  dac_cfg_regs i_dac_cfg_regs (
    .tx_clk       (tx_clk),
    .reset        (reset),
    .cfg_req      (cfg_req),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_ack      (cfg_ack),
    .enable       (enable),
    .mode         (mode),
    .const_sample (const_sample)
  );

  // Pattern source, first of the two pipeline stages
  dac_pattern_source i_dac_pattern_source (
    .tx_clk       (tx_clk),
    .reset        (reset),
    .enable       (enable),
    .mode         (mode),
    .const_sample (const_sample),
    .src_frame    (src_frame),
    .src_valid    (src_valid)
  );

  // Lane mapper, second pipeline stage
  dac_lane_mapper #(
    .LANE_ORDER (LANE_ORDER)
  ) i_dac_lane_mapper (
    .tx_clk    (tx_clk),
    .reset     (reset),
    .src_frame (src_frame),
    .src_valid (src_valid),
    .tx_data   (tx_data),
    .tx_valid  (tx_valid)
  );

endmodule

//--- tb/dac_tx_sva.sv
// Bound assertions on the host req/ack handshake and the reset state of the DAC transmit outputs
`timescale 1ns/1ps

module dac_tx_sva
  import dac_tx_pkg::*;
(
  input logic   tx_clk,
  input logic   reset,
  input logic   cfg_req,
  input logic   cfg_ack,
  input frame_t tx_data,
  input logic   tx_valid
);

  // Number of assertion failures seen so far, read by the testbench at the end
  int fail_count = 0;

  // ******************************
  // Host handshake
  // ******************************

  // Ack only answers a request that was present on the edge before
  ack_needs_req: assert property (@(posedge tx_clk) disable iff (reset)
    $rose(cfg_ack) |-> $past(cfg_req))
  else begin
    fail_count++;
    $error("cfg_ack rose without a pending cfg_req");
  end

  // Once given, ack is held for as long as the host keeps req up
  ack_held: assert property (@(posedge tx_clk) disable iff (reset)
    (cfg_ack && cfg_req) |=> cfg_ack)
  else begin
    fail_count++;
    $error("cfg_ack dropped while cfg_req was still high");
  end

  // The four-phase cycle closes soon after the host releases req
  ack_release: assert property (@(posedge tx_clk) disable iff (reset)
    $fell(cfg_req) |-> ##[0:2] !cfg_ack)
  else begin
    fail_count++;
    $error("cfg_ack did not fall within 2 cycles of cfg_req falling");
  end

  // ******************************
  // Reset state
  // ******************************

  // The link sees an idle zero frame right after any reset edge
  reset_idle: assert property (@(posedge tx_clk)
    reset |=> (!tx_valid && (tx_data == '0)))
  else begin
    fail_count++;
    $error("tx_valid or tx_data not cleared in the cycle after reset");
  end

endmodule

bind dac_tx_top dac_tx_sva i_dac_tx_sva (.*);

//--- tb/dac_tx_tb.sv
// Testbench for the DAC transmit path; runs host writes and checks every output frame against a model
`timescale 1ns/1ps

module dac_tx_tb
  import dac_tx_pkg::*;
();

  localparam int LANE_ORDER = 0;
  // Cycles any single wait may take before it is called a timeout
  localparam int WAIT_LIMIT = 20;

  logic      tx_clk;
  logic      reset;
  logic      cfg_req;
  cfg_addr_t cfg_addr;
  cfg_data_t cfg_wdata;
  logic      cfg_ack;
  frame_t    tx_data;
  logic      tx_valid;

  integer seed;
  string  test_name;
  int     frame_errs;
  int     sample_errs;
  int     bit_errs;
  int     timeout_errs;

  // Model state, one copy of each pipeline stage and the settings
  logic          en_m;
  pattern_mode_e mode_m;
  sample_t       const_m;
  sample_t       base_m;
  frame_t        src_m;
  logic          src_valid_m;
  logic          ack_m;
  frame_t        exp_data;
  logic          exp_valid;

  // Inputs as the DUT saw them on the edge that was just modelled
  logic      reset_p;
  logic      req_p;
  cfg_addr_t addr_p;
  cfg_data_t wdata_p;

  dac_tx_top #(
    .LANE_ORDER (LANE_ORDER)
  ) i_dac_tx_top (
    .tx_clk    (tx_clk),
    .reset     (reset),
    .cfg_req   (cfg_req),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_ack   (cfg_ack),
    .tx_data   (tx_data),
    .tx_valid  (tx_valid)
  );

  initial begin
    tx_clk = 1'b0;
    forever #20 tx_clk = ~tx_clk;
  end

  // ******************************
  // Reference model
  // ******************************

  // Input byte that feeds output slot t = 8j + 4b + l
  function automatic int src_octet(input int t);
    int j;
    int b;
    int l;
    int lane;
    j = t / (2 * NUM_LANES);
    b = (t / NUM_LANES) % 2;
    l = t % NUM_LANES;
    lane = (LANE_ORDER == 1) ? (NUM_LANES - 1 - l) : l;
    return 2 * (j + (OCTETS_PER_LANE / 2) * lane) + (1 - b);
  endfunction

  function automatic frame_t ref_map(input frame_t in_frame);
    frame_t out_frame;
    for (int t = 0; t < NUM_LANES * OCTETS_PER_LANE; t++) begin
      out_frame[t*8 +: 8] = in_frame[src_octet(t)*8 +: 8];
    end
    return out_frame;
  endfunction

  // Puts lane layout octets back into sample order
  function automatic frame_t unmap_frame(input frame_t lane_frame);
    frame_t sample_frame;
    for (int t = 0; t < NUM_LANES * OCTETS_PER_LANE; t++) begin
      sample_frame[src_octet(t)*8 +: 8] = lane_frame[t*8 +: 8];
    end
    return sample_frame;
  endfunction

  function automatic frame_t build_pattern(input pattern_mode_e pat_mode, input sample_t cst,
                                           input sample_t base);
    frame_t f;
    f = '0;
    for (int i = 0; i < NUM_SAMPLES; i++) begin
      if (pat_mode == MODE_CONST) begin
        f[i*SAMPLE_W +: SAMPLE_W] = cst;
      end else begin
        f[i*SAMPLE_W +: SAMPLE_W] = base + sample_t'(i);
      end
    end
    return f;
  endfunction

  // Advances the model by one edge, mapper first so each stage sees last cycle's input
  task automatic step_model();
    if (reset_p) begin
      en_m = 1'b0;
      mode_m = MODE_RAMP;
      const_m = '0;
      base_m = '0;
      src_m = '0;
      src_valid_m = 1'b0;
      ack_m = 1'b0;
      exp_data = '0;
      exp_valid = 1'b0;
    end else begin
      exp_data = ref_map(src_m);
      exp_valid = src_valid_m;
      if (!en_m) begin
        src_m = '0;
        src_valid_m = 1'b0;
        base_m = '0;
      end else begin
        src_m = build_pattern(mode_m, const_m, base_m);
        src_valid_m = 1'b1;
        if (mode_m == MODE_RAMP) begin
          base_m = base_m + sample_t'(NUM_SAMPLES);
        end
      end
      // A write lands on the edge that takes the handshake out of idle
      if (!ack_m && req_p) begin
        if (addr_p == ADDR_CTRL) begin
          en_m = wdata_p[CTRL_ENABLE_BIT];
          mode_m = wdata_p[CTRL_MODE_BIT] ? MODE_CONST : MODE_RAMP;
        end else if (addr_p == ADDR_CONST) begin
          const_m = wdata_p;
        end
      end
      ack_m = req_p;
    end
  endtask

  // ******************************
  // Compare tasks
  // ******************************

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      sample_errs++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // A bad frame is also broken down word by word to show where it differs
  task automatic check_frame(input string name, input frame_t exp, input frame_t act);
    if (act !== exp) begin
      frame_errs++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      for (int i = 0; i < NUM_SAMPLES; i++) begin
        check_sample($sformatf("%s word %0d", name, i), exp[i*SAMPLE_W +: SAMPLE_W],
                     act[i*SAMPLE_W +: SAMPLE_W]);
      end
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      bit_errs++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Model and compare on the falling edge, where all DUT outputs are settled
  initial begin
    reset_p = 1'b1;
    req_p = 1'b0;
    addr_p = '0;
    wdata_p = '0;
    forever begin
      @(negedge tx_clk);
      step_model();
      check_bit({test_name, " ack"}, ack_m, cfg_ack);
      check_bit({test_name, " valid"}, exp_valid, tx_valid);
      check_frame({test_name, " frame"}, exp_data, tx_data);
      reset_p = reset;
      req_p = cfg_req;
      addr_p = cfg_addr;
      wdata_p = cfg_wdata;
    end
  end

  // ******************************
  // Stimulus tasks
  // ******************************

  task automatic run_cycles(input int n);
    repeat (n) @(negedge tx_clk);
  endtask

  // Full four-phase write, returning on the falling edge where ack is seen low
  task automatic host_write(input cfg_addr_t addr, input cfg_data_t data);
    int cycles;
    @(posedge tx_clk);
    cfg_addr <= addr;
    cfg_wdata <= data;
    cfg_req <= 1'b1;
    cycles = 0;
    do begin
      @(negedge tx_clk);
      cycles++;
    end while (!cfg_ack && cycles < WAIT_LIMIT);
    if (!cfg_ack) begin
      timeout_errs++;
      $display("Timeout: cfg_ack never rose for a write to address %0d", addr);
    end
    @(posedge tx_clk);
    cfg_req <= 1'b0;
    cycles = 0;
    do begin
      @(negedge tx_clk);
      cycles++;
    end while (cfg_ack && cycles < WAIT_LIMIT);
    if (cfg_ack) begin
      timeout_errs++;
      $display("Timeout: cfg_ack never fell after a write to address %0d", addr);
    end
  endtask

  // The first valid frame after enable must hold samples 0 to 15
  task automatic check_ramp_start();
    frame_t samples;
    int cycles;
    cycles = 0;
    while (!tx_valid && cycles < WAIT_LIMIT) begin
      @(negedge tx_clk);
      cycles++;
    end
    if (!tx_valid) begin
      timeout_errs++;
      $display("Timeout: tx_valid never rose after enable in test %s", test_name);
    end else begin
      samples = unmap_frame(tx_data);
      for (int i = 0; i < NUM_SAMPLES; i++) begin
        check_sample($sformatf("%s start sample %0d", test_name, i), sample_t'(i),
                     samples[i*SAMPLE_W +: SAMPLE_W]);
      end
    end
  endtask

  task automatic check_const_frame(input sample_t value);
    frame_t samples;
    samples = unmap_frame(tx_data);
    check_bit({test_name, " const valid"}, 1'b1, tx_valid);
    for (int i = 0; i < NUM_SAMPLES; i++) begin
      check_sample($sformatf("%s const sample %0d", test_name, i), value,
                   samples[i*SAMPLE_W +: SAMPLE_W]);
    end
  endtask

  // ******************************
  // Test sequence
  // ******************************

  initial begin
    sample_t const_value;
    int total;
    seed = 32'hdbeaea01;
    test_name = "reset";
    frame_errs = 0;
    sample_errs = 0;
    bit_errs = 0;
    timeout_errs = 0;
    reset = 1'b1;
    cfg_req = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    repeat (2) @(posedge tx_clk);
    reset <= 1'b0;

    // Nothing leaves the DUT until it is enabled
    test_name = "idle";
    run_cycles(20);

    // Long ramp run so the base wraps past 65535
    test_name = "ramp";
    host_write(ADDR_CTRL, 16'h0001);
    check_ramp_start();
    run_cycles(4200);

    // Constant mode with a few random samples, checked 3 cycles after ack rises
    test_name = "constant";
    for (int k = 0; k < 4; k++) begin
      const_value = sample_t'($random(seed));
      host_write(ADDR_CONST, const_value);
      if (k == 0) begin
        host_write(ADDR_CTRL, 16'h0003);
      end
      run_cycles(1);
      check_const_frame(const_value);
      run_cycles(10);
    end

    // Unused addresses are acknowledged and change nothing
    // A zero word landing on either register would stop or alter the constant frames
    test_name = "unused address";
    host_write(2'd2, 16'h0000);
    host_write(2'd3, 16'h0000);
    run_cycles(10);

    // Disable empties the pipeline, then the ramp comes back from 0
    test_name = "disable";
    host_write(ADDR_CTRL, 16'h0000);
    run_cycles(1);
    check_bit("disable valid", 1'b0, tx_valid);
    check_frame("disable data", '0, tx_data);
    run_cycles(5);
    test_name = "restart";
    host_write(ADDR_CTRL, 16'h0001);
    check_ramp_start();
    run_cycles(50);

    total = frame_errs + sample_errs + bit_errs + timeout_errs
            + i_dac_tx_top.i_dac_tx_sva.fail_count;
    $display("Errors: frame %0d, sample %0d, bit %0d, timeout %0d, assertion %0d",
             frame_errs, sample_errs, bit_errs, timeout_errs,
             i_dac_tx_top.i_dac_tx_sva.fail_count);
    if (total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
design/dac_tx_pkg.sv
design/dac_cfg_regs.sv
design/dac_pattern_source.sv
design/dac_lane_mapper.sv
design/dac_tx_top.sv
tb/dac_tx_sva.sv
tb/dac_tx_tb.sv
